// ==== include/h2f_settings.svh ====
// sizing constants for the host-to-card DMA stream
`ifndef H2F_SETTINGS_SVH
`define H2F_SETTINGS_SVH

// reorder slots, also the request window
`define H2F_SLOTS 8

// 64-bit beats per 512-byte block
`define H2F_BEATS 64

// block pointer width, byte address is pointer << 9
`define H2F_PTR_W 17

// output fifo depth in words, 32 and 128 work as well
`define H2F_FIFO_DEPTH 64

`endif

// ==== design/h2f_pkg.sv ====
// shared types for the host-to-card DMA stream
`default_nettype none

`include "h2f_settings.svh"

package h2f_pkg;

   // block pointer, 512 bytes per step
   typedef logic [`H2F_PTR_W-1:0] blk_ptr_t;

   // one pio register write
   typedef struct packed {
      logic        strobe; // single cycle, no back-pressure
      logic [3:0]  addr;   // register number
      logic [63:0] data;
   } pio_wr_t;

   // one outstanding read toward host memory
   typedef struct packed {
      logic [63:0] addr; // byte address, block aligned
      logic [7:0]  tag;  // slot number in low bits
   } rd_req_t;

   // one completion beat from the host
   typedef struct packed {
      logic        strobe; // single cycle
      logic [7:0]  tag;    // upper bits nonzero means another agent
      logic [5:0]  index;  // beat within the block
      logic [63:0] data;
   } cpl_beat_t;

endpackage

`default_nettype wire

// ==== design/h2f_ctrl_regs.sv ====
// pio register decode for stop and notify pointers plus interrupt strobes
`default_nettype none

`include "h2f_settings.svh"

module h2f_ctrl_regs import h2f_pkg::*; (
   input  wire logic     clock,
   input  wire logic     i_rst,
   input  wire pio_wr_t  i_pio,
   input  wire blk_ptr_t i_done_ptr, // completed block pointer
   input  wire logic     i_done_adv, // pointer just took a new value
   output blk_ptr_t      o_stop_ptr,
   output logic [1:0]    o_irq       // bit 0 notify, bit 1 stop
);

   localparam logic [3:0] REG_STOP   = 4'd6;
   localparam logic [3:0] REG_NOTIFY = 4'd7;

   blk_ptr_t notify_ptr;
   logic     hit_stop;
   logic     hit_notify;

   // only a fresh advance counts, so a parked pointer never retriggers
   assign hit_stop   = i_done_adv && (i_done_ptr == o_stop_ptr);
   assign hit_notify = i_done_adv && (i_done_ptr == notify_ptr);

   always_ff @(posedge clock) begin
      if (i_rst) begin
         o_stop_ptr <= '0;
         notify_ptr <= '0;
         o_irq      <= '0;
      end else begin
         if (i_pio.strobe && (i_pio.addr == REG_STOP)) begin
            o_stop_ptr <= i_pio.data[`H2F_PTR_W+8:9]; // byte address down to blocks
         end
         if (i_pio.strobe && (i_pio.addr == REG_NOTIFY)) begin
            notify_ptr <= i_pio.data[`H2F_PTR_W+8:9];
         end
         o_irq <= {hit_stop, hit_notify}; // one cycle strobes
      end
   end

endmodule

`default_nettype wire

// ==== design/h2f_req_issuer.sv ====
// read request issue with stop check and eight-slot window
`default_nettype none

`include "h2f_settings.svh"

module h2f_req_issuer import h2f_pkg::*; (
   input  wire logic     clock,
   input  wire logic     i_rst,
   input  wire blk_ptr_t i_stop_ptr,
   input  wire blk_ptr_t i_rel_ptr,  // oldest block not yet drained
   input  wire logic     i_rd_ready,
   output logic          o_rd_valid,
   output rd_req_t       o_rd_req
);

   localparam int SLOT_W = $clog2(`H2F_SLOTS);

   blk_ptr_t req_ptr;   // next block to request
   blk_ptr_t in_window; // requested but not yet released
   logic     can_issue;
   logic     accept;

   // wraps cleanly since both pointers share one width
   assign in_window = req_ptr - i_rel_ptr;
   assign can_issue = (req_ptr != i_stop_ptr) && (in_window < blk_ptr_t'(`H2F_SLOTS));
   assign accept    = o_rd_valid && i_rd_ready;

   always_ff @(posedge clock) begin
      if (i_rst) begin
         req_ptr    <= '0;
         o_rd_valid <= 1'b0;
      end else if (accept) begin
         req_ptr    <= req_ptr + 1'b1;
         o_rd_valid <= 1'b0; // re-evaluate window next cycle
      end else if (!o_rd_valid && can_issue) begin
         o_rd_valid <= 1'b1; // held until taken
      end
   end

   // request fields straight from the pointer, stable while valid
   always_comb begin
      o_rd_req      = '0;
      o_rd_req.addr = 64'({req_ptr, 9'd0});
      o_rd_req.tag  = 8'(req_ptr[SLOT_W-1:0]); // slot = block mod 8
   end

endmodule

`default_nettype wire

// ==== design/h2f_reorder_buf.sv ====
// reorder RAM that places completion beats by tag and releases blocks in order
`default_nettype none

`include "h2f_settings.svh"

module h2f_reorder_buf import h2f_pkg::*; (
   input  wire logic        clock,
   input  wire logic        i_rst,
   input  wire cpl_beat_t   i_cpl,
   input  wire logic [8:0]  i_rd_addr,  // {slot, beat}
   output logic      [63:0] o_rd_data,  // one cycle after address
   output blk_ptr_t         o_done_ptr, // next block not yet complete
   output logic             o_done_adv  // high with each new pointer value
);

   localparam int SLOT_W = $clog2(`H2F_SLOTS);
   localparam int BEAT_W = $clog2(`H2F_BEATS);

   logic [63:0]       mem [`H2F_SLOTS*`H2F_BEATS];
   logic [BEAT_W-1:0] beat_cnt [`H2F_SLOTS]; // beats seen per slot
   logic [`H2F_SLOTS-1:0] filled;
   logic [SLOT_W-1:0] cpl_slot;
   logic [SLOT_W-1:0] head_slot;
   logic              accept;
   logic              last_beat;
   logic              advance;

   assign cpl_slot  = i_cpl.tag[SLOT_W-1:0];
   assign accept    = i_cpl.strobe && (i_cpl.tag[7:SLOT_W] == '0); // drop foreign tags
   // beats come in any order so count them rather than watch the index
   assign last_beat = accept && (beat_cnt[cpl_slot] == BEAT_W'(`H2F_BEATS - 1));
   assign head_slot = o_done_ptr[SLOT_W-1:0];
   assign advance   = filled[head_slot]; // at most one block per cycle

   // beat storage with registered read port
   always_ff @(posedge clock) begin
      if (accept) begin
         mem[{cpl_slot, i_cpl.index}] <= i_cpl.data;
      end
      o_rd_data <= mem[i_rd_addr];
   end

   always_ff @(posedge clock) begin
      if (i_rst) begin
         filled     <= '0;
         o_done_ptr <= '0;
         o_done_adv <= 1'b0;
         for (int s = 0; s < `H2F_SLOTS; s++) begin
            beat_cnt[s] <= '0;
         end
      end else begin
         if (accept) begin
            beat_cnt[cpl_slot] <= beat_cnt[cpl_slot] + 1'b1; // wraps to zero on last
         end
         if (advance) begin
            filled[head_slot] <= 1'b0; // slot handed to drain
         end
         if (last_beat) begin
            filled[cpl_slot] <= 1'b1;
         end
         o_done_ptr <= o_done_ptr + blk_ptr_t'(advance);
         o_done_adv <= advance;
      end
   end

endmodule

`default_nettype wire

// ==== design/h2f_drain.sv ====
// drain that reads completed blocks from the reorder RAM into the output FIFO
`default_nettype none

`include "h2f_settings.svh"

module h2f_drain import h2f_pkg::*; (
   input  wire logic        clock,
   input  wire logic        i_rst,
   input  wire blk_ptr_t    i_done_ptr,
   input  wire logic [63:0] i_rd_data,
   input  wire logic        i_fifo_credit, // room for one more word
   output logic      [8:0]  o_rd_addr,
   output blk_ptr_t         o_rel_ptr,     // block currently draining
   output logic             o_wr_strobe,
   output logic      [63:0] o_wr_data,
   output logic      [1:0]  o_inflight     // reads not yet written
);

   localparam int SLOT_W = $clog2(`H2F_SLOTS);
   localparam int BEAT_W = $clog2(`H2F_BEATS);

   logic [`H2F_PTR_W+BEAT_W-1:0] rd_ptr; // word level read pointer
   logic go;
   logic ram_valid; // RAM output holds a word this cycle

   assign o_rel_ptr  = rd_ptr[`H2F_PTR_W+BEAT_W-1:BEAT_W];
   assign o_rd_addr  = rd_ptr[SLOT_W+BEAT_W-1:0]; // {slot, beat}
   assign go         = (o_rel_ptr != i_done_ptr) && i_fifo_credit;
   assign o_inflight = {1'b0, ram_valid} + {1'b0, o_wr_strobe};

   always_ff @(posedge clock) begin
      if (i_rst) begin
         rd_ptr      <= '0;
         ram_valid   <= 1'b0;
         o_wr_strobe <= 1'b0;
      end else begin
         rd_ptr      <= rd_ptr + (`H2F_PTR_W+BEAT_W)'(go);
         ram_valid   <= go;        // RAM read stage
         o_wr_strobe <= ram_valid; // output register stage
      end
   end

   // second pipeline stage for the word itself
   always_ff @(posedge clock) begin
      if (ram_valid) begin
         o_wr_data <= i_rd_data;
      end
   end

endmodule

`default_nettype wire

// ==== design/h2f_out_fifo.sv ====
// synchronous first-word-fall-through output FIFO with credit for the drain
`default_nettype none

`include "h2f_settings.svh"

module h2f_out_fifo (
   input  wire logic        clock,
   input  wire logic        i_rst,
   input  wire logic        i_wr_strobe, // never without credit
   input  wire logic [63:0] i_wr_data,
   input  wire logic [1:0]  i_inflight,
   input  wire logic        i_fifo_read,
   output logic             o_credit,
   output logic      [63:0] o_fifo_data,
   output logic             o_fifo_valid
);

   localparam int AW = $clog2(`H2F_FIFO_DEPTH);

   logic [63:0] mem [`H2F_FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count; // one extra bit to hold full
   logic          pop;

   assign pop          = i_fifo_read && o_fifo_valid; // read on empty ignored
   assign o_fifo_valid = (count != '0);
   assign o_fifo_data  = mem[rd_ptr]; // head word shows without a read
   // words already launched from the RAM still need a place
   assign o_credit = (int'(count) + int'(i_inflight) + 1) <= `H2F_FIFO_DEPTH;

   always_ff @(posedge clock) begin
      if (i_wr_strobe) begin
         mem[wr_ptr] <= i_wr_data;
      end
   end

   always_ff @(posedge clock) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_wr_strobe) begin
            wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + (AW+1)'(i_wr_strobe) - (AW+1)'(pop);
      end
   end

endmodule

`default_nettype wire

// ==== design/h2f_top.sv ====
// host-to-card DMA stream top joining issue, reorder, drain and FIFO stages
`default_nettype none

`include "h2f_settings.svh"

module h2f_top import h2f_pkg::*; (
   input  wire logic      clock,
   input  wire logic      i_rst,
   input  wire pio_wr_t   i_pio,
   input  wire cpl_beat_t i_cpl,
   output logic           o_rd_valid,
   output rd_req_t        o_rd_req,
   input  wire logic      i_rd_ready,
   output logic [63:0]    o_fifo_data,
   output logic           o_fifo_valid,
   input  wire logic      i_fifo_read,
   output logic [1:0]     o_irq,
   output logic [31:0]    o_status
);

   blk_ptr_t    stop_ptr;
   blk_ptr_t    done_ptr;
   blk_ptr_t    rel_ptr;
   logic        done_adv;
   logic [8:0]  rd_addr;
   logic [63:0] rd_data;
   logic        wr_strobe;
   logic [63:0] wr_data;
   logic [1:0]  inflight;
   logic        credit;

   // completed bytes, zero extended
   assign o_status = {{(32-`H2F_PTR_W-9){1'b0}}, done_ptr, 9'd0};

   h2f_ctrl_regs i_ctrl_regs (
      .clock      (clock),
      .i_rst      (i_rst),
      .i_pio      (i_pio),
      .i_done_ptr (done_ptr),
      .i_done_adv (done_adv),
      .o_stop_ptr (stop_ptr),
      .o_irq      (o_irq)
   );

   h2f_req_issuer i_req_issuer (
      .clock      (clock),
      .i_rst      (i_rst),
      .i_stop_ptr (stop_ptr),
      .i_rel_ptr  (rel_ptr),
      .i_rd_ready (i_rd_ready),
      .o_rd_valid (o_rd_valid),
      .o_rd_req   (o_rd_req)
   );

   h2f_reorder_buf i_reorder_buf (
      .clock      (clock),
      .i_rst      (i_rst),
      .i_cpl      (i_cpl),
      .i_rd_addr  (rd_addr),
      .o_rd_data  (rd_data),
      .o_done_ptr (done_ptr),
      .o_done_adv (done_adv)
   );

   h2f_drain i_drain (
      .clock         (clock),
      .i_rst         (i_rst),
      .i_done_ptr    (done_ptr),
      .i_rd_data     (rd_data),
      .i_fifo_credit (credit),
      .o_rd_addr     (rd_addr),
      .o_rel_ptr     (rel_ptr),
      .o_wr_strobe   (wr_strobe),
      .o_wr_data     (wr_data),
      .o_inflight    (inflight)
   );

   h2f_out_fifo i_out_fifo (
      .clock        (clock),
      .i_rst        (i_rst),
      .i_wr_strobe  (wr_strobe),
      .i_wr_data    (wr_data),
      .i_inflight   (inflight),
      .i_fifo_read  (i_fifo_read),
      .o_credit     (credit),
      .o_fifo_data  (o_fifo_data),
      .o_fifo_valid (o_fifo_valid)
   );

endmodule

`default_nettype wire

// ==== test/h2f_clkgen.sv ====
// testbench clock source, 100 unit period
`default_nettype none

module h2f_clkgen (
   output logic o_clock
);

   initial begin
      o_clock = 1'b0;
   end

   always #50 o_clock = ~o_clock; // 50 low, 50 high

endmodule

`default_nettype wire

// ==== test/h2f_tb.sv ====
// testbench for the DMA stream with an emulated completer, case table and consumer
`default_nettype none

`include "h2f_settings.svh"

module h2f_tb import h2f_pkg::*; ();

   localparam int NCASES     = 4;
   localparam int CASE_LIMIT = 40000; // cycles per case before giving up
   localparam int SETTLE     = 40;    // quiet window for stray words or strobes
   // window plus what the fifo can still hold behind the drain
   localparam int WIN_LIMIT  = `H2F_SLOTS + (`H2F_FIFO_DEPTH + `H2F_BEATS - 1) / `H2F_BEATS;

   typedef struct packed {
      blk_ptr_t   stop;
      blk_ptr_t   notify;
      logic [3:0] stall; // reads only when a 4-bit draw reaches this
      int         words; // 64 * (stop - previous stop)
   } case_t;

   logic        clock;
   logic        i_rst;
   pio_wr_t     i_pio;
   cpl_beat_t   i_cpl;
   logic        o_rd_valid;
   rd_req_t     o_rd_req;
   logic        i_rd_ready;
   logic [63:0] o_fifo_data;
   logic        o_fifo_valid;
   logic        i_fifo_read;
   logic [1:0]  o_irq;
   logic [31:0] o_status;

   case_t       cases [NCASES];
   cpl_beat_t   pend [$]; // beats owed by the host in any order
   logic [31:0] rng = 32'hd86727e1;
   logic [3:0]  stall;
   blk_ptr_t    cur_stop;
   blk_ptr_t    prev_stop;
   logic        held;        // request left waiting at the last edge
   rd_req_t     held_req;
   logic        timed_out;
   int          accepted;    // requests taken so far
   int          consumed;    // words popped so far
   int          total_words;
   int          notify_seen;
   int          stop_seen;
   int          errors;
   int          checks;
   int          bad_cases;

   h2f_clkgen i_clkgen (.o_clock(clock));

   h2f_top i_h2f_top (
      .clock        (clock),
      .i_rst        (i_rst),
      .i_pio        (i_pio),
      .i_cpl        (i_cpl),
      .o_rd_valid   (o_rd_valid),
      .o_rd_req     (o_rd_req),
      .i_rd_ready   (i_rd_ready),
      .o_fifo_data  (o_fifo_data),
      .o_fifo_valid (o_fifo_valid),
      .i_fifo_read  (i_fifo_read),
      .o_irq        (o_irq),
      .o_status     (o_status)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_word(input string what, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at time %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_req(input rd_req_t got, input rd_req_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at time %0t: request got addr %h tag %h expected addr %h tag %h",
                  $time, got.addr, got.tag, exp.addr, exp.tag);
      end
   endtask

   task automatic check_ptr(input string what, input blk_ptr_t got, input blk_ptr_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at time %0t: %s got block %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("error at time %0t: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   // one accepted read owed back as 64 beats
   task automatic take_request(input rd_req_t got);
      rd_req_t   exp;
      cpl_beat_t b;
      exp      = '0;
      exp.addr = 64'(accepted) << 9; // blocks go out in order from zero
      exp.tag  = 8'(accepted % `H2F_SLOTS);
      check_req(got, exp);
      if (got.addr >= (64'(cur_stop) << 9)) begin
         errors++;
         $display("request for address %h lies at or beyond the stop pointer", got.addr);
      end
      accepted++;
      if (accepted > consumed / `H2F_BEATS + WIN_LIMIT) begin
         errors++;
         $display("too many blocks requested: %0d requests after %0d words drained",
                  accepted, consumed);
      end
      for (int i = 0; i < `H2F_BEATS; i++) begin
         b.strobe = 1'b1;
         b.tag    = got.tag;
         b.index  = 6'(i);
         b.data   = got.addr + 64'(8 * i); // host memory holds its own address
         pend.push_back(b);
      end
   endtask

   // host side and consumer inputs for the coming cycle
   task automatic drive_inputs();
      int pick;
      rng         = xorshift(rng);
      i_rd_ready  = rng[0] | rng[1];     // ready three times in four
      i_fifo_read = (rng[7:4] >= stall);
      i_cpl       = '0;
      if ((pend.size() > 0) && (rng[9:8] != 2'd0)) begin
         pick  = int'(rng[31:16]) % pend.size(); // shuffle across all open blocks
         i_cpl = pend[pick];
         pend.delete(pick);
      end else if (rng[15:12] == 4'd0) begin
         i_cpl.strobe = 1'b1; // beat meant for another agent
         i_cpl.tag    = {5'b00101, rng[18:16]};
         i_cpl.index  = rng[25:20];
         i_cpl.data   = {32'hbad0bad0, rng};
      end
   endtask

   // sample at the edge and drive 10 units later
   always @(posedge clock) begin
      if (!i_rst) begin
         if (o_irq[0]) begin
            notify_seen++;
         end
         if (o_irq[1]) begin
            stop_seen++;
         end
         if (o_fifo_valid && i_fifo_read) begin
            check_word("output word", o_fifo_data, 64'(consumed) << 3);
            consumed++;
         end
         if (held) begin // unaccepted request must stay put
            check_count("held request valid", int'(o_rd_valid), 1);
            check_req(o_rd_req, held_req);
         end
         held     = o_rd_valid && !i_rd_ready;
         held_req = o_rd_req;
         if (o_rd_valid && i_rd_ready) begin
            take_request(o_rd_req);
         end
      end
      #10;
      drive_inputs();
   end

   task automatic pio_write(input logic [3:0] addr, input logic [63:0] data);
      @(posedge clock);
      #10;
      i_pio = '{strobe: 1'b1, addr: addr, data: data};
      @(posedge clock);
      #10;
      i_pio = '0;
   endtask

   task automatic run_case(input int c);
      int err0;
      int cycles;
      int exp_notify;
      err0        = errors;
      stall       = cases[c].stall;
      notify_seen = 0;
      stop_seen   = 0;
      total_words = total_words + cases[c].words;
      exp_notify  = ((cases[c].notify > prev_stop) && (cases[c].notify <= cases[c].stop)) ? 1 : 0;
      pio_write(4'd7, 64'(cases[c].notify) << 9); // notify first since stop starts traffic
      cur_stop = cases[c].stop;
      pio_write(4'd6, 64'(cases[c].stop) << 9);
      cycles = 0;
      while (((consumed < total_words) || (stop_seen == 0)) && (cycles < CASE_LIMIT)) begin
         @(posedge clock);
         #10;
         cycles++;
      end
      if ((consumed < total_words) || (stop_seen == 0)) begin
         $display("timeout in case %0d: %0d of %0d words read, %0d stop strobes",
                  c, consumed, total_words, stop_seen);
         bad_cases++;
         timed_out = 1'b1;
         return;
      end
      cycles = 0;
      while (cycles < SETTLE) begin // extra words or strobes would show here
         @(posedge clock);
         #10;
         cycles++;
      end
      check_count("stop strobes", stop_seen, 1);
      check_count("notify strobes", notify_seen, exp_notify);
      check_count("words read", consumed, total_words);
      check_word("status", 64'(o_status), 64'(cases[c].stop) << 9);
      check_ptr("requested blocks", blk_ptr_t'(accepted), cases[c].stop);
      prev_stop = cases[c].stop;
      if (errors != err0) begin
         bad_cases++;
      end
      $display("case %0d: stop %0d notify %0d stall %0d words %0d errors %0d",
               c, cases[c].stop, cases[c].notify, cases[c].stall, cases[c].words, errors - err0);
   endtask

   initial begin
      i_rst       = 1'b1;
      i_pio       = '0;
      i_cpl       = '0;
      i_rd_ready  = 1'b0;
      i_fifo_read = 1'b0;
      stall       = 4'd0;
      cur_stop    = '0;
      prev_stop   = '0;
      held        = 1'b0;
      held_req    = '0;
      timed_out   = 1'b0;
      accepted    = 0;
      consumed    = 0;
      total_words = 0;
      notify_seen = 0;
      stop_seen   = 0;
      errors      = 0;
      checks      = 0;
      bad_cases   = 0;
      cases[0] = '{stop: 17'd6,  notify: 17'd3,  stall: 4'd0,  words: 384};
      cases[1] = '{stop: 17'd20, notify: 17'd25, stall: 4'd8,  words: 896}; // notify out of range
      cases[2] = '{stop: 17'd30, notify: 17'd30, stall: 4'd14, words: 640}; // both strobes at once
      cases[3] = '{stop: 17'd40, notify: 17'd33, stall: 4'd12, words: 640};
      repeat (16) @(posedge clock);
      #10;
      check_count("valid outputs after reset", int'({o_rd_valid, o_fifo_valid}), 0);
      check_count("irq after reset", int'(o_irq), 0);
      check_word("status after reset", 64'(o_status), 64'd0);
      i_rst = 1'b0;
      for (int c = 0; c < NCASES; c++) begin
         if (!timed_out) begin
            run_case(c);
         end
      end
      $display("counts: %0d cases, %0d bad, %0d checks, %0d errors",
               NCASES, bad_cases, checks, errors);
      if (!timed_out && (errors == 0)) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
design/h2f_pkg.sv
design/h2f_ctrl_regs.sv
design/h2f_req_issuer.sv
design/h2f_reorder_buf.sv
design/h2f_drain.sv
design/h2f_out_fifo.sv
design/h2f_top.sv
test/h2f_clkgen.sv
test/h2f_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module h2f_tb -f sim.f -Mdir obj_dir
	@out="$$(./obj_dir/Vh2f_tb)"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
